// File: Makefile
VERILATOR ?= verilator
TOP       := tb_ov5640_cfg
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0

SRCS := $(wildcard verilog/*.sv sim/*.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TESTS FAILED" $(LOG); then exit 1; fi; \
	if ! grep -q "TESTS PASSED" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: flist.f
verilog/cam_cfg_pkg.sv
verilog/cam_pwr_seq.sv
verilog/cam_cfg_seq.sv
verilog/cam_reg_table.sv
verilog/ov5640_cfg.sv
sim/tb_ov5640_cfg.sv

// File: sim/tb_ov5640_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ov5640_cfg import cam_cfg_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DLY = 2;           // inputs change this long after the rising edge
    localparam int RST_CYCLES = 10;
    localparam int MAX_RESP_DLY = 20;       // longest done delay of the responder
    localparam int STALL_LIMIT = 30;        // cycles without exec before a run is abandoned
    localparam int TAIL_CYCLES = 25;
    localparam logic [31:0] SEED = 32'h5bd7;
    localparam longint WATCHDOG_NS =
        2 * 3 * (POR_WAIT_CYCLES + RST_CYCLES + REG_NUM * 22) * CLK_PERIOD;

    logic                  i2c_dri_clk;
    logic                  cam_cfg_asy_rst;
    logic [PIX_W-1:0]      cam_h_pixel;
    logic [PIX_W-1:0]      cam_v_pixel;
    logic [PIX_W-1:0]      total_h_pixel;
    logic [PIX_W-1:0]      total_v_pixel;
    logic                  i2c_done;
    logic                  i2c_exec;
    logic [I2C_WORD_W-1:0] i2c_data;
    logic                  i2c_rh_wl;
    logic                  cam_init_done;

    logic [I2C_WORD_W-1:0] model_tbl [REG_NUM];  // expected word per entry

    string cur_test;
    int    test_err;
    int    pass_cnt;
    int    fail_cnt;

    ov5640_cfg dut_i (
        .i2c_dri_clk     (i2c_dri_clk),
        .cam_cfg_asy_rst (cam_cfg_asy_rst),
        .cam_h_pixel     (cam_h_pixel),
        .cam_v_pixel     (cam_v_pixel),
        .total_h_pixel   (total_h_pixel),
        .total_v_pixel   (total_v_pixel),
        .i2c_done        (i2c_done),
        .i2c_exec        (i2c_exec),
        .i2c_data        (i2c_data),
        .i2c_rh_wl       (i2c_rh_wl),
        .cam_init_done   (cam_init_done)
    );

    initial begin : clk_gen
        i2c_dri_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i2c_dri_clk = ~i2c_dri_clk;
    end

    // i2c driver stand-in that answers every exec with one done pulse
    initial begin : i2c_responder
        int delay;
        int waited;
        forever begin
            @(negedge i2c_dri_clk);
            if (i2c_exec && !cam_cfg_asy_rst) begin
                delay = 2 + int'($urandom % (MAX_RESP_DLY - 1));
                waited = 0;
                while (waited < delay && !cam_cfg_asy_rst) begin
                    @(posedge i2c_dri_clk);
                    waited++;
                end
                if (!cam_cfg_asy_rst) begin      // a reset drops the pending answer
                    #DRIVE_DLY;
                    i2c_done = 1'b1;
                    @(posedge i2c_dri_clk);
                    #DRIVE_DLY;
                    i2c_done = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    task automatic open_test(input string name);
        cur_test = name;
        test_err = 0;
    endtask

    task automatic close_test();
        if (test_err == 0) begin
            $display("[ok]   %s", cur_test);
            pass_cnt++;
        end else begin
            $display("[fail] %s (%0d errors)", cur_test, test_err);
            fail_cnt++;
        end
    endtask

    task automatic expect_word(input string what, input logic [I2C_WORD_W-1:0] expected,
                               input logic [I2C_WORD_W-1:0] actual);
        assert (actual === expected) else begin
            $display("** Error: %s: %s expected 'h%06h actual 'h%06h",
                     cur_test, what, expected, actual);
            test_err++;
        end
    endtask

    task automatic expect_bit(input string what, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("** Error: %s: %s expected %b actual %b", cur_test, what, expected, actual);
            test_err++;
        end
    endtask

    task automatic pick_resolution();
        cam_h_pixel = PIX_W'($urandom);
        cam_v_pixel = PIX_W'($urandom);
        total_h_pixel = PIX_W'($urandom);
        total_v_pixel = PIX_W'($urandom);
    endtask

    // expected sensor words with the resolution bytes taken from the current inputs
    task automatic build_model();
        model_tbl[0] = {16'h300a, 8'h00};
        model_tbl[1] = {16'h300b, 8'h00};
        model_tbl[2] = {16'h3008, 8'h82};
        model_tbl[3] = {16'h3008, 8'h02};
        model_tbl[4] = {16'h3103, 8'h02};
        model_tbl[5] = {16'h3017, 8'hff};
        model_tbl[6] = {16'h3018, 8'hff};
        model_tbl[7] = {16'h3037, 8'h13};
        model_tbl[8] = {16'h3108, 8'h01};
        model_tbl[9] = {16'h4300, 8'h61};
        model_tbl[10] = {16'h3035, 8'h11};
        model_tbl[11] = {16'h3036, 8'h3c};
        model_tbl[12] = {16'h3800, 8'h00};
        model_tbl[13] = {16'h3801, 8'h00};
        model_tbl[14] = {16'h3802, 8'h00};
        model_tbl[15] = {16'h3803, 8'h04};
        model_tbl[16] = {16'h3804, 8'h0a};
        model_tbl[17] = {16'h3805, 8'h3f};
        model_tbl[18] = {16'h3806, 8'h07};
        model_tbl[19] = {16'h3807, 8'h9b};
        model_tbl[20] = {16'h3808, 4'h0, cam_h_pixel[11:8]};
        model_tbl[21] = {16'h3809, cam_h_pixel[7:0]};
        model_tbl[22] = {16'h380a, 5'h00, cam_v_pixel[10:8]};
        model_tbl[23] = {16'h380b, cam_v_pixel[7:0]};
        model_tbl[24] = {16'h380c, 3'h0, total_h_pixel[12:8]};
        model_tbl[25] = {16'h380d, total_h_pixel[7:0]};
        model_tbl[26] = {16'h380e, 3'h0, total_v_pixel[12:8]};
        model_tbl[27] = {16'h380f, total_v_pixel[7:0]};
        model_tbl[28] = {16'h3813, 8'h06};
        model_tbl[29] = {16'h3820, 8'h46};
        model_tbl[30] = {16'h3821, 8'h01};
        model_tbl[31] = {16'h503d, 8'h00};
    endtask

    // asserts reset if it is not held yet, checks the idle outputs, releases
    task automatic apply_reset(input string tag);
        int i;
        open_test({tag, "_reset"});
        if (!cam_cfg_asy_rst) begin
            @(posedge i2c_dri_clk);
            #DRIVE_DLY;
            cam_cfg_asy_rst = 1'b1;
        end
        pick_resolution();
        build_model();
        for (i = 0; i < RST_CYCLES; i++) begin
            @(negedge i2c_dri_clk);
            if (i > 0) begin                // outputs clear on the first edge in reset
                expect_bit("exec in reset", 1'b0, i2c_exec);
                expect_bit("rh_wl in reset", 1'b1, i2c_rh_wl);
                expect_bit("init_done in reset", 1'b0, cam_init_done);
                expect_word("data in reset", '0, i2c_data);
            end
        end
        @(posedge i2c_dri_clk);
        #DRIVE_DLY;
        cam_cfg_asy_rst = 1'b0;
        close_test();
    endtask

    // counts edges from release up to the first exec
    task automatic check_power_on(input string tag, output bit seen);
        int edges;
        open_test({tag, "_por_wait"});
        seen = 1'b0;
        edges = 0;
        while (!seen && edges <= POR_WAIT_CYCLES + 4) begin
            @(posedge i2c_dri_clk);
            edges++;
            @(negedge i2c_dri_clk);
            seen = i2c_exec;
        end
        assert (seen) else begin
            $display("%s: no command was issued within %0d cycles of reset release",
                     cur_test, POR_WAIT_CYCLES + 4);
            test_err++;
        end
        if (seen) begin
            assert (edges >= POR_WAIT_CYCLES && edges <= POR_WAIT_CYCLES + 4) else begin
                $display("** Error: %s: first exec cycle expected %0d..%0d actual %0d",
                         cur_test, POR_WAIT_CYCLES, POR_WAIT_CYCLES + 4, edges);
                test_err++;
            end
        end
        close_test();
    endtask

    // entered at the negedge that shows the first exec
    task automatic follow_commands(input string tag, input int abort_at,
                                   output int execs, output bit last_done);
        bit exec_due;
        bit running;
        int idle;
        open_test({tag, "_commands"});
        execs = 0;
        exec_due = 1'b1;
        running = 1'b1;
        idle = 0;
        last_done = 1'b0;
        while (running) begin
            assert (i2c_exec === exec_due) else begin
                $display("%s: exec for command %0d %s", cur_test, execs,
                         exec_due ? "did not follow the done" : "came without a done");
                test_err++;
            end
            if (i2c_exec) begin
                assert (execs < REG_NUM) else begin
                    $display("%s: more than %0d commands were issued", cur_test, REG_NUM);
                    test_err++;
                end
                if (execs < REG_NUM) begin
                    expect_word($sformatf("entry %0d word", execs), model_tbl[execs], i2c_data);
                    expect_bit($sformatf("entry %0d rh_wl", execs), execs < READ_NUM, i2c_rh_wl);
                end
                execs++;
                idle = 0;
            end
            expect_bit("init_done before the last done", 1'b0, cam_init_done);
            exec_due = i2c_done && (execs < REG_NUM);   // next exec one cycle after done
            if (abort_at > 0 && execs == abort_at) begin
                running = 1'b0;
            end else if (i2c_done && execs == REG_NUM) begin
                last_done = 1'b1;
                running = 1'b0;
            end else if (idle > STALL_LIMIT) begin
                $display("%s: sequence stalled after %0d commands", cur_test, execs);
                test_err++;
                running = 1'b0;
            end else begin
                @(negedge i2c_dri_clk);
                idle++;
            end
        end
        close_test();
    endtask

    task automatic check_completion(input string tag, input int execs, input bit last_done);
        int i;
        open_test({tag, "_completion"});
        assert (execs == REG_NUM && last_done) else begin
            $display("** Error: %s: command count expected %0d actual %0d",
                     cur_test, REG_NUM, execs);
            test_err++;
        end
        @(negedge i2c_dri_clk);
        expect_bit("init_done one cycle after the last done", 1'b1, cam_init_done);
        for (i = 0; i < TAIL_CYCLES; i++) begin
            expect_bit("exec after init_done", 1'b0, i2c_exec);
            expect_bit("init_done held", 1'b1, cam_init_done);
            expect_word("resting word", {ID_HI_ADDR, 8'h00}, i2c_data);
            @(negedge i2c_dri_clk);
        end
        close_test();
    endtask

    // abort_at of 0 runs the whole table
    task automatic run_config(input string tag, input int abort_at);
        bit seen;
        bit last_done;
        int execs;
        apply_reset(tag);
        check_power_on(tag, seen);
        if (seen) begin
            follow_commands(tag, abort_at, execs, last_done);
            if (abort_at == 0)
                check_completion(tag, execs, last_done);
        end
    endtask

    initial begin : main_seq
        int abort_at;
        void'($urandom(SEED));
        cam_cfg_asy_rst = 1'b1;
        i2c_done = 1'b0;
        cam_h_pixel = '0;
        cam_v_pixel = '0;
        total_h_pixel = '0;
        total_v_pixel = '0;
        pass_cnt = 0;
        fail_cnt = 0;

        abort_at = 1 + int'($urandom % (REG_NUM - 1));
        $display("run1 is cut short after %0d commands", abort_at);
        run_config("run1", abort_at);
        run_config("run2", 0);      // starts on a reset taken mid-sequence
        run_config("run3", 0);      // starts on a reset taken after completion

        $display("tests run %0d, pass %0d, fail %0d", pass_cnt + fail_cnt, pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/cam_cfg_pkg.sv
`default_nettype none

package cam_cfg_pkg;

    // table size and index width
    localparam int unsigned REG_NUM = 32;       // entries issued per start-up
    localparam int unsigned IDX_W = 6;          // index also has to reach REG_NUM itself

    // power-on wait
    // scl runs at 250 kHz, 4 us per cycle, 5000 cycles gives the 20 ms the sensor needs
    localparam int unsigned POR_WAIT_CYCLES = 5000;
    localparam int unsigned POR_CNT_W = 13;

    // leading entries read back the chip id
    localparam int unsigned READ_NUM = 2;

    // resolution inputs
    localparam int unsigned PIX_W = 13;

    // i2c command word layout
    localparam int unsigned I2C_ADDR_W = 16;    // sensor register address
    localparam int unsigned I2C_DATA_W = 8;     // sensor register data
    localparam int unsigned I2C_WORD_W = I2C_ADDR_W + I2C_DATA_W;

    // chip id high byte, also the resting word once the table is done
    localparam logic [I2C_ADDR_W-1:0] ID_HI_ADDR = 16'h300a;

endpackage

`default_nettype wire

// File: verilog/cam_cfg_seq.sv
`timescale 1ns/1ps
`default_nettype none

module cam_cfg_seq import cam_cfg_pkg::*; (
    input  logic           i2c_dri_clk,
    input  logic           local_rst,
    input  logic           por_start,
    input  logic           i2c_done,
    output logic [IDX_W:0] cfg_idx,
    output logic           i2c_exec,
    output logic           i2c_rh_wl,
    output logic           cam_init_done
);

    logic more_left;
    logic last_acked;

    assign more_left = (cfg_idx < (IDX_W + 1)'(REG_NUM));
    assign last_acked = i2c_done && (cfg_idx == (IDX_W + 1)'(REG_NUM));

    // one command in flight, the next exec waits for done
    always_ff @(posedge i2c_dri_clk) begin
        if (local_rst)
            i2c_exec <= 1'b0;
        else
            i2c_exec <= por_start || (i2c_done && more_left);
    end

    // entry counter, moves on with every issued command
    always_ff @(posedge i2c_dri_clk) begin
        if (local_rst)
            cfg_idx <= '0;
        else if (i2c_exec)
            cfg_idx <= cfg_idx + 1'b1;
    end

    // chip id reads first, then writes until reset
    always_ff @(posedge i2c_dri_clk) begin
        if (local_rst)
            i2c_rh_wl <= 1'b1;
        else if (cfg_idx == (IDX_W + 1)'(READ_NUM))
            i2c_rh_wl <= 1'b0;
    end

    always_ff @(posedge i2c_dri_clk) begin
        if (local_rst)
            cam_init_done <= 1'b0;
        else if (last_acked)
            cam_init_done <= 1'b1;      // held until the next reset
    end

    // done arrives two or more cycles after exec, so exec never stretches
    a_exec_pulse: assert property (@(posedge i2c_dri_clk) disable iff (local_rst)
        i2c_exec |=> !i2c_exec);

    a_idx_range: assert property (@(posedge i2c_dri_clk) disable iff (local_rst)
        cfg_idx <= (IDX_W + 1)'(REG_NUM));

    a_done_sticky: assert property (@(posedge i2c_dri_clk) disable iff (local_rst)
        cam_init_done |=> cam_init_done);

    // no further command once the sensor is configured
    a_quiet_after_done: assert property (@(posedge i2c_dri_clk) disable iff (local_rst)
        cam_init_done |-> !i2c_exec);

endmodule

`default_nettype wire

// File: verilog/cam_pwr_seq.sv
`timescale 1ns/1ps
`default_nettype none

module cam_pwr_seq import cam_cfg_pkg::*; (
    input  logic i2c_dri_clk,
    input  logic cam_cfg_asy_rst,
    output logic local_rst,
    output logic por_start
);

    logic rst_meta;
    logic rst_sync;
    logic [POR_CNT_W-1:0] por_cnt;

    // asserts at once, releases on the second edge after the external reset drops
    always_ff @(posedge i2c_dri_clk or posedge cam_cfg_asy_rst) begin
        if (cam_cfg_asy_rst) begin
            rst_meta <= 1'b1;
            rst_sync <= 1'b1;
        end else begin
            rst_meta <= 1'b0;
            rst_sync <= rst_meta;
        end
    end

    assign local_rst = rst_sync;

    always_ff @(posedge i2c_dri_clk) begin
        if (local_rst) begin
            por_cnt <= '0;
            por_start <= 1'b0;
        end else begin
            if (por_cnt < POR_CNT_W'(POR_WAIT_CYCLES))
                por_cnt <= por_cnt + 1'b1;      // sticks at the wait length
            por_start <= (por_cnt == POR_CNT_W'(POR_WAIT_CYCLES - 1));
        end
    end

    // counter saturates, so start can only fire once per reset
    a_por_single: assert property (@(posedge i2c_dri_clk) disable iff (local_rst)
        por_start |=> !por_start);

endmodule

`default_nettype wire

// File: verilog/cam_reg_table.sv
`timescale 1ns/1ps
`default_nettype none

module cam_reg_table import cam_cfg_pkg::*; (
    input  logic                  i2c_dri_clk,
    input  logic                  local_rst,
    input  logic [IDX_W:0]        cfg_idx,
    input  logic [PIX_W-1:0]      cam_h_pixel,
    input  logic [PIX_W-1:0]      cam_v_pixel,
    input  logic [PIX_W-1:0]      total_h_pixel,
    input  logic [PIX_W-1:0]      total_v_pixel,
    output logic [I2C_WORD_W-1:0] i2c_data
);

    logic [I2C_WORD_W-1:0] tbl_word;

    // address in the upper bits, data byte below
    function automatic logic [I2C_WORD_W-1:0] reg_word(
        input logic [I2C_ADDR_W-1:0] addr,
        input logic [I2C_DATA_W-1:0] data
    );
        return {addr, data};
    endfunction

    always_comb begin
        case (32'(cfg_idx))
            // chip id, read back
            0:  tbl_word = reg_word(ID_HI_ADDR, 8'h00);
            1:  tbl_word = reg_word(16'h300b, 8'h00);

            // soft reset, then back to normal mode
            2:  tbl_word = reg_word(16'h3008, 8'h82);
            3:  tbl_word = reg_word(16'h3008, 8'h02);
            4:  tbl_word = reg_word(16'h3103, 8'h02);  // system clock from pll
            5:  tbl_word = reg_word(16'h3017, 8'hff);  // pad output enable, sync/clk/d[9:6]
            6:  tbl_word = reg_word(16'h3018, 8'hff);  // pad output enable, d[5:0]/gpio
            7:  tbl_word = reg_word(16'h3037, 8'h13);  // pll pre-divider
            8:  tbl_word = reg_word(16'h3108, 8'h01);  // root clock divider

            // output format and pixel clock
            9:  tbl_word = reg_word(16'h4300, 8'h61);  // rgb565
            10: tbl_word = reg_word(16'h3035, 8'h11);  // system clock divide
            11: tbl_word = reg_word(16'h3036, 8'h3c);  // pll multiplier

            // sensor window start and end
            12: tbl_word = reg_word(16'h3800, 8'h00);
            13: tbl_word = reg_word(16'h3801, 8'h00);
            14: tbl_word = reg_word(16'h3802, 8'h00);
            15: tbl_word = reg_word(16'h3803, 8'h04);
            16: tbl_word = reg_word(16'h3804, 8'h0a);
            17: tbl_word = reg_word(16'h3805, 8'h3f);
            18: tbl_word = reg_word(16'h3806, 8'h07);
            19: tbl_word = reg_word(16'h3807, 8'h9b);

            // dvp output size
            20: tbl_word = reg_word(16'h3808, {4'd0, cam_h_pixel[11:8]});
            21: tbl_word = reg_word(16'h3809, cam_h_pixel[7:0]);
            22: tbl_word = reg_word(16'h380a, {5'd0, cam_v_pixel[10:8]});
            23: tbl_word = reg_word(16'h380b, cam_v_pixel[7:0]);

            // total line and frame size, blanking included
            24: tbl_word = reg_word(16'h380c, {3'd0, total_h_pixel[12:8]});
            25: tbl_word = reg_word(16'h380d, total_h_pixel[7:0]);
            26: tbl_word = reg_word(16'h380e, {3'd0, total_v_pixel[12:8]});
            27: tbl_word = reg_word(16'h380f, total_v_pixel[7:0]);

            // vertical offset, mirror/flip and binning
            28: tbl_word = reg_word(16'h3813, 8'h06);
            29: tbl_word = reg_word(16'h3820, 8'h46);
            30: tbl_word = reg_word(16'h3821, 8'h01);

            31: tbl_word = reg_word(16'h503d, 8'h00);  // test pattern off, 8'h80 gives colour bars

            // past the table the word points at a read-only register,
            // so a stray exec cannot rewrite anything
            default: tbl_word = reg_word(ID_HI_ADDR, 8'h00);
        endcase
    end

    // one cycle behind cfg_idx, settled well before the next exec
    always_ff @(posedge i2c_dri_clk) begin
        if (local_rst)
            i2c_data <= '0;
        else
            i2c_data <= tbl_word;
    end

endmodule

`default_nettype wire

// File: verilog/ov5640_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module ov5640_cfg import cam_cfg_pkg::*; (
    input  logic                  i2c_dri_clk,
    input  logic                  cam_cfg_asy_rst,
    input  logic [PIX_W-1:0]      cam_h_pixel,
    input  logic [PIX_W-1:0]      cam_v_pixel,
    input  logic [PIX_W-1:0]      total_h_pixel,   // line length incl. blanking
    input  logic [PIX_W-1:0]      total_v_pixel,   // frame length incl. blanking
    input  logic                  i2c_done,
    output logic                  i2c_exec,
    output logic [I2C_WORD_W-1:0] i2c_data,        // {addr, data}
    output logic                  i2c_rh_wl,       // 1 read, 0 write
    output logic                  cam_init_done
);

    logic           local_rst;
    logic           por_start;
    logic [IDX_W:0] cfg_idx;

    // reset release and power-on wait
    cam_pwr_seq pwr_seq_i (
        .i2c_dri_clk     (i2c_dri_clk),
        .cam_cfg_asy_rst (cam_cfg_asy_rst),
        .local_rst       (local_rst),
        .por_start       (por_start)
    );

    cam_cfg_seq cfg_seq_i (
        .i2c_dri_clk   (i2c_dri_clk),
        .local_rst     (local_rst),
        .por_start     (por_start),
        .i2c_done      (i2c_done),
        .cfg_idx       (cfg_idx),
        .i2c_exec      (i2c_exec),
        .i2c_rh_wl     (i2c_rh_wl),
        .cam_init_done (cam_init_done)
    );

    // register words, indexed by the sequencer
    cam_reg_table reg_table_i (
        .i2c_dri_clk   (i2c_dri_clk),
        .local_rst     (local_rst),
        .cfg_idx       (cfg_idx),
        .cam_h_pixel   (cam_h_pixel),
        .cam_v_pixel   (cam_v_pixel),
        .total_h_pixel (total_h_pixel),
        .total_v_pixel (total_v_pixel),
        .i2c_data      (i2c_data)
    );

endmodule

`default_nettype wire
